/* rtl/exu_pkg.sv */
package exu_pkg;

   localparam int xlen       = 32;
   localparam int reg_addr_w = 5;
   localparam int sel_w      = xlen / 8;

   // which unit handles the issued instruction
   typedef enum logic [1:0] {
      unit_alu = 2'd0,
      unit_bru = 2'd1,
      unit_lsu = 2'd2
   } unit_e;

   typedef enum logic [3:0] {
      alu_add  = 4'd0,
      alu_sub  = 4'd1,
      alu_and  = 4'd2,
      alu_or   = 4'd3,
      alu_xor  = 4'd4,
      alu_sll  = 4'd5,
      alu_srl  = 4'd6,
      alu_sra  = 4'd7,
      alu_slt  = 4'd8,
      alu_sltu = 4'd9,
      alu_lui  = 4'd10
   } alu_op_e;

   typedef enum logic [2:0] {
      bru_beq  = 3'd0,
      bru_bne  = 3'd1,
      bru_blt  = 3'd2,
      bru_bge  = 3'd3,
      bru_bltu = 3'd4,
      bru_bgeu = 3'd5,
      bru_jirl = 3'd6
   } bru_op_e;

   typedef enum logic [2:0] {
      lsu_ld_w  = 3'd0,
      lsu_ld_b  = 3'd1,
      lsu_ld_bu = 3'd2,
      lsu_st_w  = 3'd3,
      lsu_st_b  = 3'd4
   } lsu_op_e;

   typedef struct packed {
      logic                  valid;
      unit_e                 unit;
      alu_op_e               alu_op;
      bru_op_e               bru_op;
      lsu_op_e               lsu_op;
      logic [xlen-1:0]       a;
      logic [xlen-1:0]       b;
      logic [xlen-1:0]       imm;
      logic [xlen-1:0]       pc;
      logic [reg_addr_w-1:0] rd;
      logic                  wen;
   } exu_issue_t;

   // wishbone classic, master side
   typedef struct packed {
      logic             cyc;
      logic             stb;
      logic             we;
      logic [xlen-1:0]  adr;
      logic [sel_w-1:0] sel;
      logic [xlen-1:0]  dat_w;
   } wb_req_t;

   typedef struct packed {
      logic            ack;
      logic [xlen-1:0] dat_r;
   } wb_rsp_t;

   typedef struct packed {
      logic                  wen;
      logic [reg_addr_w-1:0] addr;
      logic [xlen-1:0]       data;
   } rf_write_t;

endpackage

/* rtl/exu_regfile.sv */
`timescale 1ns/1ps

module exu_regfile
   import exu_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  rf_write_t             wr,
   input  logic [reg_addr_w-1:0] rs1_addr,
   input  logic [reg_addr_w-1:0] rs2_addr,
   output logic [xlen-1:0]       rs1_data,
   output logic [xlen-1:0]       rs2_data
);

   // no storage behind register 0
   logic [xlen-1:0] regs [1:(1 << reg_addr_w) - 1];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 1; i < (1 << reg_addr_w); i++) begin
            regs[i] <= '0;
         end
      end else if (wr.wen && wr.addr != '0) begin
         regs[wr.addr] <= wr.data;
      end
   end

   // reads see the old value during a write
   assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
   assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

   a_wr_addr_known: assert property (
      @(posedge clk) disable iff (!rst_n)
      wr.wen |-> !$isunknown(wr.addr)
   );

endmodule

/* rtl/exu_alu.sv */
`timescale 1ns/1ps

module exu_alu
   import exu_pkg::*;
(
   input  alu_op_e         op,
   input  logic [xlen-1:0] a,
   input  logic [xlen-1:0] b,
   output logic [xlen-1:0] result
);

   logic [4:0] shamt;

   assign shamt = b[4:0];

   always_comb begin
      case (op)
         alu_add: begin
            result = a + b;
         end
         alu_sub: begin
            result = a - b;
         end
         alu_and: begin
            result = a & b;
         end
         alu_or: begin
            result = a | b;
         end
         alu_xor: begin
            result = a ^ b;
         end
         alu_sll: begin
            result = a << shamt;
         end
         alu_srl: begin
            result = a >> shamt;
         end
         alu_sra: begin
            result = $signed(a) >>> shamt;
         end
         alu_slt: begin
            result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
         end
         alu_sltu: begin
            result = {{(xlen-1){1'b0}}, a < b};
         end
         // upper immediate sits in b
         alu_lui: begin
            result = b << 12;
         end
         default: begin
            result = '0;
         end
      endcase
   end

endmodule

/* rtl/exu_branch.sv */
`timescale 1ns/1ps

module exu_branch
   import exu_pkg::*;
(
   input  bru_op_e         op,
   input  logic [xlen-1:0] a,
   input  logic [xlen-1:0] b,
   input  logic [xlen-1:0] pc,
   input  logic [xlen-1:0] offset,
   output logic            taken,
   output logic [xlen-1:0] target,
   output logic [xlen-1:0] link
);

   always_comb begin
      case (op)
         bru_beq:  taken = (a == b);
         bru_bne:  taken = (a != b);
         bru_blt:  taken = ($signed(a) < $signed(b));
         bru_bge:  taken = ($signed(a) >= $signed(b));
         bru_bltu: taken = (a < b);
         bru_bgeu: taken = (a >= b);
         bru_jirl: taken = 1'b1;
         default:  taken = 1'b0;
      endcase
   end

   // jirl is register relative, the rest pc relative
   assign target = (op == bru_jirl) ? a + offset : pc + offset;
   assign link   = pc + xlen'(4);

endmodule

/* rtl/exu_lsu.sv */
`timescale 1ns/1ps

module exu_lsu
   import exu_pkg::*;
(
   input  logic            clk,
   input  logic            rst_n,
   input  logic            start,
   input  lsu_op_e         op,
   input  logic [xlen-1:0] addr,
   input  logic [xlen-1:0] wdata,
   output wb_req_t         wb_req,
   input  wb_rsp_t         wb_rsp,
   output logic            done,
   output logic [xlen-1:0] rdata
);

   typedef enum logic {
      st_idle,
      st_bus
   } lsu_state_e;

   lsu_state_e       state;
   lsu_op_e          op_q;
   logic             we_q;
   logic [xlen-1:0]  adr_q;
   logic [sel_w-1:0] sel_q;
   logic [xlen-1:0]  dat_q;
   logic             is_word;
   logic             is_store;
   logic [7:0]       lane_byte;

   assign is_word  = (op == lsu_ld_w) || (op == lsu_st_w);
   assign is_store = (op == lsu_st_w) || (op == lsu_st_b);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle: if (start) state <= st_bus;
            st_bus:  if (wb_rsp.ack) state <= st_idle;
            default: state <= st_idle;
         endcase
      end
   end

   // request captured at bus start and held for the whole cycle
   always_ff @(posedge clk) begin
      if (state == st_idle && start) begin
         op_q  <= op;
         we_q  <= is_store;
         adr_q <= addr;
         sel_q <= is_word ? '1 : sel_w'(1) << addr[1:0];
         dat_q <= is_word ? wdata : wdata << (8 * addr[1:0]);
      end
   end

   assign wb_req.cyc   = (state == st_bus);
   assign wb_req.stb   = (state == st_bus);
   assign wb_req.we    = we_q;
   assign wb_req.adr   = adr_q;
   assign wb_req.sel   = sel_q;
   assign wb_req.dat_w = dat_q;

   assign done = (state == st_bus) && wb_rsp.ack;

   assign lane_byte = wb_rsp.dat_r[8 * adr_q[1:0] +: 8];

   always_comb begin
      case (op_q)
         lsu_ld_b:  rdata = {{(xlen-8){lane_byte[7]}}, lane_byte};
         lsu_ld_bu: rdata = {{(xlen-8){1'b0}}, lane_byte};
         default:   rdata = wb_rsp.dat_r;
      endcase
   end

   a_word_aligned: assert property (
      @(posedge clk) disable iff (!rst_n)
      start && is_word |-> addr[1:0] == 2'b00
   );

   // slave acks only inside an open cycle
   a_ack_in_cycle: assert property (
      @(posedge clk) disable iff (!rst_n)
      wb_rsp.ack |-> wb_req.cyc && wb_req.stb
   );

endmodule

/* rtl/exu_ecl.sv */
`timescale 1ns/1ps

module exu_ecl
   import exu_pkg::*;
(
   input  logic            clk,
   input  logic            rst_n,
   input  exu_issue_t      issue,
   input  logic [xlen-1:0] alu_result,
   input  logic            br_taken_in,
   input  logic [xlen-1:0] br_link,
   input  logic            lsu_done,
   input  logic [xlen-1:0] lsu_rdata,
   output logic            lsu_start,
   output logic            stall,
   output logic            br_taken,
   output rf_write_t       wr
);

   logic busy;
   logic is_lsu;
   logic is_load;

   assign is_lsu  = issue.valid && (issue.unit == unit_lsu);
   assign is_load = (issue.lsu_op == lsu_ld_w) || (issue.lsu_op == lsu_ld_b) ||
                    (issue.lsu_op == lsu_ld_bu);

   // one memory op in flight at a time
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy <= 1'b0;
      end else if (lsu_done) begin
         busy <= 1'b0;
      end else if (lsu_start) begin
         busy <= 1'b1;
      end
   end

   assign lsu_start = is_lsu && !busy;
   assign stall     = is_lsu && !lsu_done;
   assign br_taken  = issue.valid && (issue.unit == unit_bru) && br_taken_in;

   always_comb begin
      wr.addr = issue.rd;
      case (issue.unit)
         unit_bru: begin
            wr.wen  = issue.valid && issue.wen;
            wr.data = br_link;
         end
         // loads retire on the ack edge
         unit_lsu: begin
            wr.wen  = issue.valid && issue.wen && is_load && lsu_done;
            wr.data = lsu_rdata;
         end
         default: begin
            wr.wen  = issue.valid && issue.wen;
            wr.data = alu_result;
         end
      endcase
   end

   // front end must hold the instruction while stalled
   a_issue_hold: assert property (
      @(posedge clk) disable iff (!rst_n)
      stall |=> $stable(issue)
   );

endmodule

/* rtl/exu_top.sv */
`timescale 1ns/1ps

module exu_top
   import exu_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  exu_issue_t            issue,
   output logic                  stall,
   input  logic [reg_addr_w-1:0] rs1_addr,
   input  logic [reg_addr_w-1:0] rs2_addr,
   output logic [xlen-1:0]       rs1_data,
   output logic [xlen-1:0]       rs2_data,
   output logic                  br_taken,
   output logic [xlen-1:0]       br_target,
   output wb_req_t               wb_req,
   input  wb_rsp_t               wb_rsp
);

   logic [xlen-1:0] alu_result;
   logic            bru_taken;
   logic [xlen-1:0] bru_link;
   logic            lsu_start;
   logic            lsu_done;
   logic [xlen-1:0] lsu_rdata;
   rf_write_t       rf_wr;

   exu_ecl ecl (
      .clk         (clk),
      .rst_n       (rst_n),
      .issue       (issue),
      .alu_result  (alu_result),
      .br_taken_in (bru_taken),
      .br_link     (bru_link),
      .lsu_done    (lsu_done),
      .lsu_rdata   (lsu_rdata),
      .lsu_start   (lsu_start),
      .stall       (stall),
      .br_taken    (br_taken),
      .wr          (rf_wr)
   );

   exu_regfile regfile (
      .clk      (clk),
      .rst_n    (rst_n),
      .wr       (rf_wr),
      .rs1_addr (rs1_addr),
      .rs2_addr (rs2_addr),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data)
   );

   exu_alu alu (
      .op     (issue.alu_op),
      .a      (issue.a),
      .b      (issue.b),
      .result (alu_result)
   );

   exu_branch bru (
      .op     (issue.bru_op),
      .a      (issue.a),
      .b      (issue.b),
      .pc     (issue.pc),
      .offset (issue.imm),
      .taken  (bru_taken),
      .target (br_target),
      .link   (bru_link)
   );

   // effective address is base plus offset
   exu_lsu lsu (
      .clk    (clk),
      .rst_n  (rst_n),
      .start  (lsu_start),
      .op     (issue.lsu_op),
      .addr   (issue.a + issue.imm),
      .wdata  (issue.b),
      .wb_req (wb_req),
      .wb_rsp (wb_rsp),
      .done   (lsu_done),
      .rdata  (lsu_rdata)
   );

endmodule

/* dv/tb_exu.sv */
`timescale 1ns/1ps

module tb_exu
   import exu_pkg::*;
();

   localparam int reset_cycles    = 8;
   localparam int cycles_per_line = 12;
   localparam int mem_words       = 256;

   // one line of the golden file
   typedef struct packed {
      logic [1:0]            unit;
      logic [3:0]            op;
      logic [xlen-1:0]       a;
      logic [xlen-1:0]       b;
      logic [xlen-1:0]       imm;
      logic [xlen-1:0]       pc;
      logic [reg_addr_w-1:0] rd;
      logic                  wen;
      logic [xlen-1:0]       exp_val;
      logic                  exp_taken;
      logic [xlen-1:0]       exp_target;
   } golden_t;

   logic                  clk = 1'b0;
   logic                  rst_n;
   exu_issue_t            issue;
   logic                  stall;
   logic [reg_addr_w-1:0] rs1_addr;
   logic [reg_addr_w-1:0] rs2_addr;
   logic [xlen-1:0]       rs1_data;
   logic [xlen-1:0]       rs2_data;
   logic                  br_taken;
   logic [xlen-1:0]       br_target;
   wb_req_t               wb_req;
   wb_rsp_t               wb_rsp = '0;

   golden_t         vectors[$];
   logic [xlen-1:0] mem [0:mem_words-1];
   logic [1:0]      wait_cnt;
   integer          seed = 32'h40da_5cf0;
   int              n_checks = 0;
   int              n_errors = 0;
   int              n_acks = 0;
   int              n_lsu = 0;
   logic            loaded = 1'b0;

   exu_top exu_top_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .issue     (issue),
      .stall     (stall),
      .rs1_addr  (rs1_addr),
      .rs2_addr  (rs2_addr),
      .rs1_data  (rs1_data),
      .rs2_data  (rs2_data),
      .br_taken  (br_taken),
      .br_target (br_target),
      .wb_req    (wb_req),
      .wb_rsp    (wb_rsp)
   );

   always #2 clk = ~clk;

   // wishbone slave memory with 0 to 3 wait cycles per access
   always @(posedge clk) begin
      if (!rst_n) begin
         wb_rsp   <= '0;
         wait_cnt <= 2'($random(seed));
         n_acks   <= 0;
         for (int i = 0; i < mem_words; i++) begin
            mem[i] <= 32'h5a5a_0000 | 32'(i);
         end
      end else if (wb_rsp.ack) begin
         wb_rsp.ack <= 1'b0;
         wait_cnt   <= 2'($random(seed));
      end else if (wb_req.cyc && wb_req.stb) begin
         if (wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
         end else begin
            wb_rsp.ack   <= 1'b1;
            wb_rsp.dat_r <= mem[wb_req.adr[9:2]];
            n_acks       <= n_acks + 1;
            for (int k = 0; k < sel_w; k++) begin
               if (wb_req.we && wb_req.sel[k]) begin
                  mem[wb_req.adr[9:2]][8*k +: 8] <= wb_req.dat_w[8*k +: 8];
               end
            end
         end
      end
   end

   task automatic check_val(input string name, input logic [xlen-1:0] got,
                            input logic [xlen-1:0] exp);
      n_checks++;
      assert (got === exp) else begin
         n_errors++;
         $display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic load_golden();
      int              fd;
      int              n;
      string           line;
      logic [xlen-1:0] f [0:10];
      golden_t         v;
      fd = $fopen("dv/exu_golden.txt", "r");
      if (fd == 0) begin
         n_errors++;
         $display("could not open the golden file dv/exu_golden.txt");
         return;
      end
      while ($fgets(line, fd)) begin
         if (line.len() > 0 && line[0] != "#") begin
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                        f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
            if (n == 11) begin
               v.unit       = f[0][1:0];
               v.op         = f[1][3:0];
               v.a          = f[2];
               v.b          = f[3];
               v.imm        = f[4];
               v.pc         = f[5];
               v.rd         = f[6][reg_addr_w-1:0];
               v.wen        = f[7][0];
               v.exp_val    = f[8];
               v.exp_taken  = f[9][0];
               v.exp_target = f[10];
               vectors.push_back(v);
            end
         end
      end
      $fclose(fd);
   endtask

   task automatic check_reset_state();
      @(negedge clk);
      check_val("stall", stall, '0);
      check_val("wb_req.cyc", wb_req.cyc, '0);
      check_val("wb_req.stb", wb_req.stb, '0);
      check_val("br_taken", br_taken, '0);
      for (int i = 1; i < (1 << reg_addr_w); i++) begin
         @(posedge clk);
         rs1_addr <= reg_addr_w'(i);
         rs2_addr <= reg_addr_w'((1 << reg_addr_w) - i);
         @(negedge clk);
         check_val("rs1_data", rs1_data, '0);
         check_val("rs2_data", rs2_data, '0);
      end
   endtask

   // present one instruction, hold it through the stall, then read rd back
   task automatic run_line(input golden_t v);
      exu_issue_t ins;
      logic       is_lsu;
      logic       is_store;
      int         n;
      ins       = '0;
      ins.valid = 1'b1;
      ins.unit  = unit_e'(v.unit);
      ins.a     = v.a;
      ins.b     = v.b;
      ins.imm   = v.imm;
      ins.pc    = v.pc;
      ins.rd    = v.rd;
      ins.wen   = v.wen;
      case (v.unit)
         2'd1:    ins.bru_op = bru_op_e'(v.op[2:0]);
         2'd2:    ins.lsu_op = lsu_op_e'(v.op[2:0]);
         default: ins.alu_op = alu_op_e'(v.op);
      endcase
      is_lsu   = (v.unit == 2'd2);
      is_store = is_lsu && (ins.lsu_op == lsu_st_w || ins.lsu_op == lsu_st_b);
      n = 0;
      @(posedge clk);
      issue    <= ins;
      rs1_addr <= v.rd;
      @(negedge clk);
      check_val("br_taken", br_taken, v.exp_taken);
      if (v.unit == 2'd1) begin
         check_val("br_target", br_target, v.exp_target);
      end
      forever begin
         check_val("stall", stall, is_lsu && !wb_rsp.ack);
         check_val("wb_req.cyc", wb_req.cyc, is_lsu && n > 0);
         check_val("wb_req.stb", wb_req.stb, is_lsu && n > 0);
         // address is base plus offset, held for the whole cycle
         if (is_lsu && n > 0) begin
            check_val("wb_req.adr", wb_req.adr, v.a + v.imm);
            check_val("wb_req.we", wb_req.we, is_store);
         end
         if (!stall) begin
            break;
         end
         n++;
         @(negedge clk);
      end
      // accepted on this edge
      @(posedge clk);
      issue <= '0;
      @(negedge clk);
      if (v.wen) begin
         check_val("rs1_data", rs1_data, v.exp_val);
      end
   endtask

   task automatic print_counts();
      $display("checks run: %0d, errors: %0d", n_checks, n_errors);
   endtask

   initial begin
      rst_n    = 1'b0;
      issue    = '0;
      rs1_addr = '0;
      rs2_addr = '0;
      load_golden();
      loaded = 1'b1;
      repeat (reset_cycles) @(posedge clk);
      rst_n <= 1'b1;
      check_reset_state();
      if (vectors.size() == 0) begin
         n_errors++;
         $display("the golden file holds no instructions");
      end
      foreach (vectors[i]) begin
         if (vectors[i].unit == 2'd2) begin
            n_lsu++;
         end
         run_line(vectors[i]);
      end
      check_val("wb_rsp.ack count", n_acks, n_lsu);
      print_counts();
      if (n_errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // reset, register sweep, then a fixed budget per golden line
   initial begin
      wait (loaded === 1'b1);
      repeat (reset_cycles + (1 << reg_addr_w) + vectors.size() * cycles_per_line) begin
         @(posedge clk);
      end
      n_errors++;
      $display("timeout: the golden instructions did not all complete in time");
      print_counts();
      $display("Simulation failed");
      $finish;
   end

endmodule

/* dv/exu_golden.txt */
# unit(0 alu,1 bru,2 lsu) op a b imm pc rd wen exp_val exp_taken exp_target
# all fields hex; exp_val is read from rd after acceptance when wen is 1
0 0 00001234 00005678 00000000 00000000 01 1 000068ac 0 00000000
0 1 00000010 00000020 00000000 00000000 02 1 fffffff0 0 00000000
0 2 f0f0ff00 0ff0f0f0 00000000 00000000 03 1 00f0f000 0 00000000
0 3 f0000000 0000000f 00000000 00000000 04 1 f000000f 0 00000000
0 4 aaaa5555 ffff0000 00000000 00000000 05 1 55555555 0 00000000
0 5 00000001 0000003f 00000000 00000000 06 1 80000000 0 00000000
0 6 80000000 00000004 00000000 00000000 07 1 08000000 0 00000000
0 7 80000000 00000004 00000000 00000000 08 1 f8000000 0 00000000
0 8 ffffffff 00000001 00000000 00000000 09 1 00000001 0 00000000
0 9 00000001 ffffffff 00000000 00000000 0a 1 00000001 0 00000000
0 a 00000000 00012345 00000000 00000000 0b 1 12345000 0 00000000
0 0 00000001 00000001 00000000 00000000 00 1 00000000 0 00000000
1 0 00000005 00000005 00000010 00001000 00 0 00000000 1 00001010
1 1 00000005 00000005 00000020 00001004 00 0 00000000 0 00001024
1 2 ffffffff 00000001 fffffff0 00001008 00 0 00000000 1 00000ff8
1 3 ffffffff 00000001 00000008 0000100c 00 0 00000000 0 00001014
1 4 00000001 ffffffff 00000100 00001010 00 0 00000000 1 00001110
1 5 00000001 ffffffff 00000004 00001014 00 0 00000000 0 00001018
1 6 00002000 00000000 0000000c 00001018 0c 1 0000101c 1 0000200c
2 3 00000100 cafe8877 00000020 00000000 00 0 00000000 0 00000000
2 0 00000100 00000000 00000020 00000000 0d 1 cafe8877 0 00000000
2 4 00000100 000000a5 00000021 00000000 00 0 00000000 0 00000000
2 0 00000100 00000000 00000020 00000000 0e 1 cafea577 0 00000000
2 1 00000100 00000000 00000021 00000000 0f 1 ffffffa5 0 00000000
2 2 00000100 00000000 00000021 00000000 10 1 000000a5 0 00000000
2 1 00000100 00000000 00000020 00000000 11 1 00000077 0 00000000
2 1 00000100 00000000 00000023 00000000 12 1 ffffffca 0 00000000
2 0 00000140 00000000 ffffffe0 00000000 13 1 cafea577 0 00000000

/* list.f */
rtl/exu_pkg.sv
rtl/exu_regfile.sv
rtl/exu_alu.sv
rtl/exu_branch.sv
rtl/exu_lsu.sv
rtl/exu_ecl.sv
rtl/exu_top.sv
dv/tb_exu.sv

/* Bender.yml */
package:
  name: exu

sources:
  - files:
      - rtl/exu_pkg.sv
      - rtl/exu_regfile.sv
      - rtl/exu_alu.sv
      - rtl/exu_branch.sv
      - rtl/exu_lsu.sv
      - rtl/exu_ecl.sv
      - rtl/exu_top.sv
  - target: test
    files:
      - dv/tb_exu.sv
